// File: src/jtag_dbg_pkg.sv
/*
 * Shared definitions for the JTAG debug transport and system-bus access.
 * JTAG instruction codes, DMI scan layout and op codes,
 * DMI register addresses and SBCS bit positions.
 */

`default_nettype none

package jtag_dbg_pkg;

  // JTAG instruction register
  localparam int unsigned IR_LEN = 5;

  localparam logic [IR_LEN-1:0] IR_IDCODE = 5'h01;
  localparam logic [IR_LEN-1:0] IR_DMI    = 5'h11;
  localparam logic [IR_LEN-1:0] IR_BYPASS = 5'h1f;

  // DMI scan is {addr, data, op}, op shifted out first
  localparam int unsigned DMI_ABITS    = 7;
  localparam int unsigned DMI_DBITS    = 32;
  localparam int unsigned DMI_SCAN_LEN = DMI_ABITS + DMI_DBITS + 2;

  typedef enum logic [1:0] {
    DMI_NOP   = 2'd0,
    DMI_READ  = 2'd1,
    DMI_WRITE = 2'd2
  } dmi_op_e;

  typedef logic [DMI_ABITS-1:0] dmi_addr_t;
  typedef logic [DMI_DBITS-1:0] dmi_data_t;
  typedef logic [31:0]          sb_addr_t;

  // System bus registers of the debug module
  localparam dmi_addr_t DMI_SBCS    = 7'h38;
  localparam dmi_addr_t DMI_SBADDR0 = 7'h39;
  localparam dmi_addr_t DMI_SBDATA0 = 7'h3c;

  // SBCS fields
  localparam int unsigned SBCS_READONDATA = 15;
  localparam int unsigned SBCS_AUTOINC    = 16;
  localparam int unsigned SBCS_READONADDR = 20;
  localparam int unsigned SBCS_BUSY       = 21;

  // sbaccess = 2 (32 bit) in bits 19:17, fixed
  localparam dmi_data_t SBCS_ACCESS32 = 32'h0004_0000;

endpackage

`default_nettype wire

// File: src/dmi_if.sv
/*
 * DMI request channel from the TAP to the system-bus register block.
 */

`timescale 1ns/1ns
`default_nettype none

interface dmi_if
  import jtag_dbg_pkg::*;
();

  // One-cycle request strobe with its op, address and write data
  logic      req;
  dmi_op_e   op;
  dmi_addr_t addr;
  dmi_data_t wdata;

  // Read data of the register last read, and access in flight
  dmi_data_t rdata;
  logic      busy;

  modport tap  (output req, op, addr, wdata, input  rdata, busy);
  modport regs (input  req, op, addr, wdata, output rdata, busy);

endinterface

`default_nettype wire

// File: src/sbus_if.sv
/*
 * System-bus word access channel from the SB registers to the memory.
 */

`timescale 1ns/1ns
`default_nettype none

interface sbus_if
  import jtag_dbg_pkg::*;
();

  logic      req;
  logic      we;
  sb_addr_t  addr;
  dmi_data_t wdata;
  // Valid the cycle after a read request
  dmi_data_t rdata;

  modport master (output req, we, addr, wdata, input  rdata);
  modport slave  (input  req, we, addr, wdata, output rdata);

endinterface

`default_nettype wire

// File: src/jtag_tap.sv
/*
 * JTAG TAP controller with a 5-bit instruction register.
 * Data registers are IDCODE, BYPASS and the 41-bit DMI scan chain,
 * which issues DMI requests at Update-DR.
 */

`timescale 1ns/1ns
`default_nettype none

module jtag_tap
  import jtag_dbg_pkg::*;
#(
  parameter logic [31:0] IdCode = 32'h10a5_3cd1
) (
  input  logic jtag_tck,
  input  logic reset_i,
  input  logic tms_i,
  input  logic tdi_i,
  output logic tdo_o,
  dmi_if.tap   dmi
);

  typedef enum logic [3:0] {
    TEST_LOGIC_RESET, RUN_TEST_IDLE,
    SELECT_DR, CAPTURE_DR, SHIFT_DR, EXIT1_DR, PAUSE_DR, EXIT2_DR, UPDATE_DR,
    SELECT_IR, CAPTURE_IR, SHIFT_IR, EXIT1_IR, PAUSE_IR, EXIT2_IR, UPDATE_IR
  } tap_state_e;

  typedef enum logic [1:0] {DR_BYPASS, DR_IDCODE, DR_DMI} dr_sel_e;

  tap_state_e state_q, state_d;
  dr_sel_e    dr_sel;

  logic [IR_LEN-1:0]       ir_q;
  logic [IR_LEN-1:0]       ir_sr_q;
  logic [31:0]             idcode_sr_q;
  logic                    bypass_q;
  logic [DMI_SCAN_LEN-1:0] dmi_sr_q;

  logic      req_q;
  dmi_op_e   op_q;
  dmi_addr_t addr_q;
  dmi_data_t wdata_q;

  //////////////////////////////////////////////////////////////////////
  // TAP state machine
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (state_q)
      TEST_LOGIC_RESET: state_d = tms_i ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
      RUN_TEST_IDLE:    state_d = tms_i ? SELECT_DR : RUN_TEST_IDLE;
      SELECT_DR:        state_d = tms_i ? SELECT_IR : CAPTURE_DR;
      CAPTURE_DR:       state_d = tms_i ? EXIT1_DR : SHIFT_DR;
      SHIFT_DR:         state_d = tms_i ? EXIT1_DR : SHIFT_DR;
      EXIT1_DR:         state_d = tms_i ? UPDATE_DR : PAUSE_DR;
      PAUSE_DR:         state_d = tms_i ? EXIT2_DR : PAUSE_DR;
      EXIT2_DR:         state_d = tms_i ? UPDATE_DR : SHIFT_DR;
      UPDATE_DR:        state_d = tms_i ? SELECT_DR : RUN_TEST_IDLE;
      SELECT_IR:        state_d = tms_i ? TEST_LOGIC_RESET : CAPTURE_IR;
      CAPTURE_IR:       state_d = tms_i ? EXIT1_IR : SHIFT_IR;
      SHIFT_IR:         state_d = tms_i ? EXIT1_IR : SHIFT_IR;
      EXIT1_IR:         state_d = tms_i ? UPDATE_IR : PAUSE_IR;
      PAUSE_IR:         state_d = tms_i ? EXIT2_IR : PAUSE_IR;
      EXIT2_IR:         state_d = tms_i ? UPDATE_IR : SHIFT_IR;
      UPDATE_IR:        state_d = tms_i ? SELECT_DR : RUN_TEST_IDLE;
      default:          state_d = TEST_LOGIC_RESET;
    endcase
  end

  always_ff @(posedge jtag_tck) begin
    if (reset_i) begin
      state_q <= TEST_LOGIC_RESET;
      ir_q    <= IR_IDCODE;
    end else begin
      state_q <= state_d;
      if (state_q == TEST_LOGIC_RESET) begin
        ir_q <= IR_IDCODE;
      end else if (state_q == UPDATE_IR) begin
        ir_q <= ir_sr_q;
      end
    end
  end

  // IR capture pattern ends in 01 as the standard asks
  always_ff @(posedge jtag_tck) begin
    if (state_q == CAPTURE_IR) begin
      ir_sr_q <= IR_LEN'(1);
    end else if (state_q == SHIFT_IR) begin
      ir_sr_q <= {tdi_i, ir_sr_q[IR_LEN-1:1]};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Data registers
  //////////////////////////////////////////////////////////////////////

  // Unknown instructions fall back to bypass
  always_comb begin
    case (ir_q)
      IR_IDCODE: dr_sel = DR_IDCODE;
      IR_DMI:    dr_sel = DR_DMI;
      IR_BYPASS: dr_sel = DR_BYPASS;
      default:   dr_sel = DR_BYPASS;
    endcase
  end

  always_ff @(posedge jtag_tck) begin
    if (state_q == CAPTURE_DR) begin
      idcode_sr_q <= IdCode;
      bypass_q    <= 1'b0;
      // Last request's address with the latched read data, status ok
      dmi_sr_q    <= {addr_q, dmi.rdata, DMI_NOP};
    end else if (state_q == SHIFT_DR) begin
      case (dr_sel)
        DR_IDCODE: idcode_sr_q <= {tdi_i, idcode_sr_q[31:1]};
        DR_DMI:    dmi_sr_q    <= {tdi_i, dmi_sr_q[DMI_SCAN_LEN-1:1]};
        default:   bypass_q    <= tdi_i;
      endcase
    end
  end

  // TDO follows the shift register, so it changes on the shifting edge
  always_comb begin
    tdo_o = 1'b0;
    if (state_q == SHIFT_IR) begin
      tdo_o = ir_sr_q[0];
    end else if (state_q == SHIFT_DR) begin
      case (dr_sel)
        DR_IDCODE: tdo_o = idcode_sr_q[0];
        DR_DMI:    tdo_o = dmi_sr_q[0];
        default:   tdo_o = bypass_q;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // DMI request
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge jtag_tck) begin
    if (reset_i) begin
      req_q  <= 1'b0;
      addr_q <= '0;
    end else begin
      req_q <= 1'b0;
      if (state_q == UPDATE_DR && dr_sel == DR_DMI &&
          dmi_sr_q[1:0] inside {DMI_READ, DMI_WRITE}) begin
        req_q  <= 1'b1;
        addr_q <= dmi_sr_q[DMI_SCAN_LEN-1 -: DMI_ABITS];
      end
    end
  end

  always_ff @(posedge jtag_tck) begin
    if (state_q == UPDATE_DR && dr_sel == DR_DMI) begin
      op_q    <= dmi_op_e'(dmi_sr_q[1:0]);
      wdata_q <= dmi_sr_q[DMI_DBITS+1:2];
    end
  end

  assign dmi.req   = req_q;
  assign dmi.op    = op_q;
  assign dmi.addr  = addr_q;
  assign dmi.wdata = wdata_q;

  // A DMI scan is far longer than any bus access
  a_req_single: assert property (@(posedge jtag_tck) disable iff (reset_i)
    dmi.req |=> !dmi.req);
  a_req_not_busy: assert property (@(posedge jtag_tck) disable iff (reset_i)
    dmi.req |-> !dmi.busy);

endmodule

`default_nettype wire

// File: src/sba_regs.sv
/*
 * System-bus access registers SBCS, SBAddress0 and SBData0.
 * Starts bus accesses on read-on-address, read-on-data and data writes,
 * applies autoincrement and tracks busy.
 */

`timescale 1ns/1ns
`default_nettype none

module sba_regs
  import jtag_dbg_pkg::*;
(
  input  logic   jtag_tck,
  input  logic   reset_i,
  dmi_if.regs    dmi,
  sbus_if.master sbus
);

  // SBCS control bits
  logic readondata_q;
  logic autoinc_q;
  logic readonaddr_q;

  sb_addr_t  sbaddr_q;
  dmi_data_t sbdata_q;
  dmi_data_t rdata_q;

  // Bus access in progress, rd_pend_q is the data return cycle
  logic sb_req_q;
  logic sb_we_q;
  logic rd_pend_q;
  logic busy;

  dmi_data_t sbcs;
  dmi_data_t reg_rdata;
  logic      wr_sbcs;
  logic      wr_addr;
  logic      wr_data;
  logic      rd_sbdata;

  assign busy = (sb_req_q & ~sb_we_q) | rd_pend_q;

  always_comb begin
    sbcs                  = SBCS_ACCESS32;
    sbcs[SBCS_BUSY]       = busy;
    sbcs[SBCS_READONADDR] = readonaddr_q;
    sbcs[SBCS_AUTOINC]    = autoinc_q;
    sbcs[SBCS_READONDATA] = readondata_q;
  end

  always_comb begin
    case (dmi.addr)
      DMI_SBCS:    reg_rdata = sbcs;
      DMI_SBADDR0: reg_rdata = sbaddr_q;
      DMI_SBDATA0: reg_rdata = sbdata_q;
      default:     reg_rdata = '0;
    endcase
  end

  assign wr_sbcs   = dmi.req && dmi.op == DMI_WRITE && dmi.addr == DMI_SBCS;
  assign wr_addr   = dmi.req && dmi.op == DMI_WRITE && dmi.addr == DMI_SBADDR0;
  assign wr_data   = dmi.req && dmi.op == DMI_WRITE && dmi.addr == DMI_SBDATA0;
  assign rd_sbdata = dmi.req && dmi.op == DMI_READ && dmi.addr == DMI_SBDATA0;

  //////////////////////////////////////////////////////////////////////
  // Register updates and bus sequencing
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge jtag_tck) begin
    if (reset_i) begin
      readondata_q <= 1'b0;
      autoinc_q    <= 1'b0;
      readonaddr_q <= 1'b0;
      sbaddr_q     <= '0;
      sbdata_q     <= '0;
      rdata_q      <= '0;
      sb_req_q     <= 1'b0;
      sb_we_q      <= 1'b0;
      rd_pend_q    <= 1'b0;
    end else begin
      sb_req_q  <= 1'b0;
      rd_pend_q <= sb_req_q & ~sb_we_q;

      if (wr_sbcs) begin
        readondata_q <= dmi.wdata[SBCS_READONDATA];
        autoinc_q    <= dmi.wdata[SBCS_AUTOINC];
        readonaddr_q <= dmi.wdata[SBCS_READONADDR];
      end

      // Latched here, before read-on-data replaces SBData0
      if (dmi.req && dmi.op == DMI_READ) begin
        rdata_q <= reg_rdata;
      end

      // Address, advanced after every bus access when autoincrement is on
      if (wr_addr) begin
        sbaddr_q <= dmi.wdata;
        if (readonaddr_q) begin
          sb_req_q <= 1'b1;
          sb_we_q  <= 1'b0;
        end
      end else if (sb_req_q && autoinc_q) begin
        sbaddr_q <= sbaddr_q + 32'd4;
      end

      if (wr_data) begin
        sbdata_q <= dmi.wdata;
        sb_req_q <= 1'b1;
        sb_we_q  <= 1'b1;
      end else if (rd_sbdata && readondata_q) begin
        sb_req_q <= 1'b1;
        sb_we_q  <= 1'b0;
      end else if (rd_pend_q) begin
        sbdata_q <= sbus.rdata;
      end
    end
  end

  assign sbus.req   = sb_req_q;
  assign sbus.we    = sb_we_q;
  assign sbus.addr  = sbaddr_q;
  assign sbus.wdata = sbdata_q;

  assign dmi.rdata = rdata_q;
  assign dmi.busy  = busy;

  // No new access while read data is still on its way back
  a_no_req_busy: assert property (@(posedge jtag_tck) disable iff (reset_i)
    sbus.req |-> !rd_pend_q);

endmodule

`default_nettype wire

// File: src/sba_mem.sv
/*
 * Word memory behind the system bus, addresses wrap at MemWords.
 */

`timescale 1ns/1ns
`default_nettype none

module sba_mem
  import jtag_dbg_pkg::*;
#(
  parameter int unsigned MemWords = 256
) (
  input  logic  jtag_tck,
  input  logic  reset_i,
  sbus_if.slave sbus
);

  localparam int unsigned IdxWidth = $clog2(MemWords);

  dmi_data_t             mem_q [MemWords];
  dmi_data_t             rdata_q;
  logic [IdxWidth-1:0]   idx;

  // Byte address to word index, upper bits dropped
  assign idx = sbus.addr[IdxWidth+1:2];

  always_ff @(posedge jtag_tck) begin
    if (sbus.req && sbus.we) begin
      mem_q[idx] <= sbus.wdata;
    end
  end

  always_ff @(posedge jtag_tck) begin
    if (reset_i) begin
      rdata_q <= '0;
    end else if (sbus.req && !sbus.we) begin
      rdata_q <= mem_q[idx];
    end
  end

  assign sbus.rdata = rdata_q;

  // Only 32-bit accesses are issued
  a_word_aligned: assert property (@(posedge jtag_tck) disable iff (reset_i)
    sbus.req |-> sbus.addr[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: src/jtag_dbg_top.sv
/*
 * Top level of the JTAG debug path.
 * TAP, system-bus registers and word memory.
 */

`timescale 1ns/1ns
`default_nettype none

module jtag_dbg_top #(
  parameter logic [31:0] IdCode   = 32'h10a5_3cd1,
  parameter int unsigned MemWords = 256
) (
  input  logic jtag_tck,
  input  logic reset_i,
  input  logic tms_i,
  input  logic tdi_i,
  output logic tdo_o
);

  dmi_if  u_dmi ();
  sbus_if u_sbus ();

  jtag_tap #(
    .IdCode (IdCode)
  ) u_tap (
    .jtag_tck (jtag_tck),
    .reset_i  (reset_i),
    .tms_i    (tms_i),
    .tdi_i    (tdi_i),
    .tdo_o    (tdo_o),
    .dmi      (u_dmi.tap)
  );

  sba_regs u_regs (
    .jtag_tck (jtag_tck),
    .reset_i  (reset_i),
    .dmi      (u_dmi.regs),
    .sbus     (u_sbus.master)
  );

  sba_mem #(
    .MemWords (MemWords)
  ) u_mem (
    .jtag_tck (jtag_tck),
    .reset_i  (reset_i),
    .sbus     (u_sbus.slave)
  );

endmodule

`default_nettype wire

// File: bench/tb_jtag_dbg.sv
/*
 * Testbench for the JTAG debug path.
 * Clock and reset, JTAG scan tasks, DMI access tasks,
 * a memory and register model, and the checks against it.
 */

`timescale 1ns/1ns
`default_nettype none

module tb_jtag_dbg;

  localparam logic [31:0] ID_CODE     = 32'h1c0ffee1;
  localparam int          MEM_WORDS   = 256;
  localparam int          NWORDS      = 8;
  // DMI req, sbus req and two cycles of read latency
  localparam int          IDLE_CYCLES = 4;

  localparam logic [4:0]  IR_DMI    = 5'h11;
  localparam logic [4:0]  IR_BYPASS = 5'h1f;
  localparam logic [1:0]  OP_NOP    = 2'd0;
  localparam logic [1:0]  OP_READ   = 2'd1;
  localparam logic [1:0]  OP_WRITE  = 2'd2;
  localparam logic [6:0]  A_SBCS    = 7'h38;
  localparam logic [6:0]  A_SBADDR0 = 7'h39;
  localparam logic [6:0]  A_SBDATA0 = 7'h3c;

  // SBCS control fields
  localparam logic [31:0] F_READONDATA = 32'h0000_8000;
  localparam logic [31:0] F_AUTOINC    = 32'h0001_0000;
  localparam logic [31:0] F_READONADDR = 32'h0010_0000;
  // sbaccess reads as 2 in bits 19:17
  localparam logic [31:0] ACCESS32     = 32'h0004_0000;
  localparam logic [31:0] CTRL_MASK    = F_READONDATA | F_AUTOINC | F_READONADDR;

  logic   jtag_tck;
  logic   reset_i;
  logic   tms_i;
  logic   tdi_i;
  logic   tdo_o;
  integer seed;
  integer errors;
  integer checks;

  // Model of memory and SB registers
  logic [31:0] mem_m [MEM_WORDS];
  logic [31:0] sbcs_m;
  logic [31:0] addr_m;
  logic [31:0] data_m;

  initial begin
    jtag_tck = 1'b0;
    forever #5 jtag_tck = ~jtag_tck;
  end

  jtag_dbg_top #(
    .IdCode   (ID_CODE),
    .MemWords (MEM_WORDS)
  ) u_dut (
    .jtag_tck (jtag_tck),
    .reset_i  (reset_i),
    .tms_i    (tms_i),
    .tdi_i    (tdi_i),
    .tdo_o    (tdo_o)
  );

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("error at %0t ns: %s, got %08h, expected %08h", $time, what, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // JTAG scans
  //////////////////////////////////////////////////////////////////////

  // Inputs act at the next edge while tdo shows the current state
  task automatic clock_step(input logic tms, input logic tdi, output logic tdo);
    @(posedge jtag_tck);
    #1;
    tms_i = tms;
    tdi_i = tdi;
    tdo   = tdo_o;
  endtask

  task automatic apply_reset();
    @(posedge jtag_tck);
    #1;
    reset_i = 1'b1;
    tms_i   = 1'b0;
    repeat (5) @(posedge jtag_tck);
    #1;
    reset_i = 1'b0;
  endtask

  task automatic tms_reset();
    logic tdo;
    int   i;
    for (i = 0; i < 5; i++) begin
      clock_step(1'b1, 1'b0, tdo);
    end
    clock_step(1'b0, 1'b0, tdo);
  endtask

  // Scans end in an Update state with TMS low for the way back to Run-Test/Idle
  task automatic ir_scan(input logic [4:0] code);
    logic tdo;
    int   i;
    clock_step(1'b1, 1'b0, tdo);
    clock_step(1'b1, 1'b0, tdo);
    clock_step(1'b0, 1'b0, tdo);
    clock_step(1'b0, 1'b0, tdo);
    for (i = 0; i < 5; i++) begin
      clock_step(i == 4, code[i], tdo);
    end
    clock_step(1'b1, 1'b0, tdo);
    clock_step(1'b0, 1'b0, tdo);
  endtask

  task automatic dr_scan(input int n, input logic [63:0] din, output logic [63:0] dout);
    logic tdo;
    int   i;
    dout = '0;
    clock_step(1'b1, 1'b0, tdo);
    clock_step(1'b0, 1'b0, tdo);
    clock_step(1'b0, 1'b0, tdo);
    for (i = 0; i < n; i++) begin
      clock_step(i == n - 1, din[i], tdo);
      dout[i] = tdo;
    end
    clock_step(1'b1, 1'b0, tdo);
    clock_step(1'b0, 1'b0, tdo);
  endtask

  task automatic verify_idcode(input string what);
    logic [63:0] out;
    dr_scan(32, 64'h0, out);
    check_eq(out[31:0], ID_CODE, what);
  endtask

  task automatic verify_bypass(input logic [4:0] code);
    logic [31:0] pattern;
    logic [63:0] out;
    pattern = $random(seed);
    ir_scan(code);
    dr_scan(33, {32'h0, pattern}, out);
    check_eq({31'h0, out[0]}, 32'h0, "bypass leading bit");
    check_eq(out[32:1], pattern, "bypass data");
  endtask

  //////////////////////////////////////////////////////////////////////
  // DMI accesses
  //////////////////////////////////////////////////////////////////////

  // prev is the data captured from the request before this one
  task automatic dmi_access(input logic [1:0] op, input logic [6:0] addr,
                            input logic [31:0] wdata, output logic [31:0] prev);
    logic [63:0] dout;
    logic        tdo;
    int          idle;
    dr_scan(41, {23'h0, addr, wdata, op}, dout);
    prev = dout[33:2];
    for (idle = 0; idle < IDLE_CYCLES; idle++) begin
      clock_step(1'b0, 1'b0, tdo);
    end
  endtask

  task automatic write_reg(input logic [6:0] addr, input logic [31:0] wdata);
    logic [31:0] prev;
    dmi_access(OP_WRITE, addr, wdata, prev);
  endtask

  task automatic read_reg(input logic [6:0] addr, output logic [31:0] rdata);
    logic [31:0] prev;
    dmi_access(OP_READ, addr, 32'h0, prev);
    dmi_access(OP_NOP, 7'h0, 32'h0, rdata);
  endtask

  task automatic wait_sb_idle();
    logic [31:0] sbcs;
    int          polls;
    polls = 0;
    read_reg(A_SBCS, sbcs);
    while (sbcs[21] && polls < 8) begin
      polls = polls + 1;
      read_reg(A_SBCS, sbcs);
    end
    if (sbcs[21]) begin
      $display("timeout: sbbusy still set after %0d SBCS polls", polls);
      $display("Checks failed");
      $finish;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    logic [31:0] w;
    logic [31:0] base;
    logic [6:0]  ua;
    logic [4:0]  code;
    int          k;
    seed    = 32'hd7e7;
    errors  = 0;
    checks  = 0;
    reset_i = 1'b1;
    tms_i   = 1'b0;
    tdi_i   = 1'b0;

    apply_reset();
    verify_idcode("IDCODE after reset");
    verify_bypass(IR_BYPASS);
    r    = $random(seed);
    code = r[4:0];
    if (code == 5'h01 || code == 5'h11 || code == 5'h1f) begin
      code = 5'h0a;
    end
    verify_bypass(code);
    apply_reset();
    verify_idcode("IDCODE after second reset");
    ir_scan(IR_BYPASS);
    tms_reset();
    verify_idcode("IDCODE after TMS reset");

    // SBCS control bits and unmapped registers
    ir_scan(IR_DMI);
    for (k = 0; k < 4; k++) begin
      w      = $random(seed);
      sbcs_m = (w & CTRL_MASK) | ACCESS32;
      write_reg(A_SBCS, w);
      read_reg(A_SBCS, r);
      check_eq(r, sbcs_m, "SBCS readback");
      r  = $random(seed);
      ua = r[6:0];
      if (ua == A_SBCS || ua == A_SBADDR0 || ua == A_SBDATA0) begin
        ua = 7'h11;
      end
      write_reg(ua, $random(seed));
      read_reg(ua, r);
      check_eq(r, 32'h0, "unmapped DMI register");
    end

    // Autoincrement writes
    write_reg(A_SBCS, F_AUTOINC);
    base   = $random(seed);
    base   = {base[31:2], 2'b00};
    addr_m = base;
    write_reg(A_SBADDR0, addr_m);
    for (k = 0; k < NWORDS; k++) begin
      w = $random(seed);
      write_reg(A_SBDATA0, w);
      mem_m[addr_m[9:2]] = w;
      addr_m = addr_m + 32'd4;
    end
    read_reg(A_SBADDR0, r);
    check_eq(r, addr_m, "SBAddress0 after autoincrement");

    // Burst with read-on-address and read-on-data runs one scan behind
    write_reg(A_SBCS, F_READONADDR | F_READONDATA | F_AUTOINC);
    addr_m = base;
    write_reg(A_SBADDR0, addr_m);
    wait_sb_idle();
    for (k = 0; k < NWORDS; k++) begin
      dmi_access(OP_READ, A_SBDATA0, 32'h0, r);
      if (k > 0) begin
        check_eq(r, mem_m[addr_m[9:2]], "read-on-data burst word");
        addr_m = addr_m + 32'd4;
      end
    end
    dmi_access(OP_NOP, 7'h0, 32'h0, r);
    check_eq(r, mem_m[addr_m[9:2]], "read-on-data last word");

    // Single reads at addresses that wrap above 1 KiB
    write_reg(A_SBCS, F_READONADDR);
    for (k = 0; k < 6; k++) begin
      r      = $random(seed);
      addr_m = base + {r[31:11], 1'b1, 10'h0} + {27'h0, r[2:0], 2'b00};
      write_reg(A_SBADDR0, addr_m);
      wait_sb_idle();
      read_reg(A_SBDATA0, r);
      check_eq(r, mem_m[addr_m[9:2]], "read-on-address word");
    end

    // Repeated writes to one address
    write_reg(A_SBCS, 32'h0);
    r      = $random(seed);
    addr_m = {r[31:2], 2'b00};
    write_reg(A_SBADDR0, addr_m);
    for (k = 0; k < 3; k++) begin
      data_m = $random(seed);
      write_reg(A_SBDATA0, data_m);
      mem_m[addr_m[9:2]] = data_m;
    end
    read_reg(A_SBADDR0, r);
    check_eq(r, addr_m, "SBAddress0 without autoincrement");
    read_reg(A_SBDATA0, r);
    check_eq(r, data_m, "SBData0 holds last write");
    write_reg(A_SBCS, F_READONADDR);
    write_reg(A_SBADDR0, addr_m);
    wait_sb_idle();
    read_reg(A_SBDATA0, r);
    check_eq(r, mem_m[addr_m[9:2]], "memory keeps last write");

    $display("%0d checks run, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
src/jtag_dbg_pkg.sv
src/dmi_if.sv
src/sbus_if.sv
src/jtag_tap.sv
src/sba_regs.sv
src/sba_mem.sv
src/jtag_dbg_top.sv
bench/tb_jtag_dbg.sv

// File: run.sh
#!/bin/sh
# Build and run the JTAG debug path simulation with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f flist.f --top-module tb_jtag_dbg

if ! ./obj_dir/Vtb_jtag_dbg > sim.log 2>&1; then
  cat sim.log
  exit 1
fi
cat sim.log

if grep -q "Checks failed" sim.log; then
  exit 1
fi
exit 0
